// ==== Makefile ====
# Verilator build and run of the trigger controller testbench

VERILATOR ?= verilator
TOP       ?= tlu_controller_tb
OBJ_DIR   ?= obj_dir
FLAGS     ?= --binary --timing --assert
PASS_MSG  ?= Finished with no errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench, fail unless it passes"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): sources.f
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f sources.f

test: $(OBJ_DIR)/V$(TOP)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== common/tlu_pkg.sv ====
// Shared types of the trigger controller.
// Register map, trigger FSM states and the FIFO word layout.
`include "tlu_settings.svh"

package tlu_pkg;

    // byte addresses on the register bus
    typedef enum logic [7:0] {
        ADDR_RESET_VERSION = 8'd0,   // write resets, read gives version
        ADDR_CONF          = 8'd1,   // bit 3 is trigger enable
        ADDR_CNT0          = 8'd8,   // read latches the counter
        ADDR_CNT1          = 8'd9,
        ADDR_CNT2          = 8'd10,
        ADDR_CNT3          = 8'd11,  // write presets the counter
        ADDR_LOST          = 8'd12,
        ADDR_TRG_SELECT    = 8'd13,
        ADDR_VETO_SELECT   = 8'd17,
        ADDR_TRG_INVERT    = 8'd21,
        ADDR_CNT_MAX0      = 8'd25,
        ADDR_CNT_MAX1      = 8'd26,
        ADDR_CNT_MAX2      = 8'd27,
        ADDR_CNT_MAX3      = 8'd28,
        ADDR_THRESHOLD     = 8'd33,
        ADDR_SOFT_TRG      = 8'd34   // write only, fires one trigger
    } reg_addr_t;

    typedef enum logic [2:0] {
        IDLE,
        QUALIFY,   // counting threshold cycles
        ACCEPT,    // single cycle, word is written
        WAIT_ACK,
        WAIT_LOW
    } trg_state_t;

    // one FIFO entry
    typedef struct packed {
        logic        marker;   // always 1
        logic [30:0] number;
    } trigger_word_t;

endpackage

// ==== common/tlu_settings.svh ====
// Build-time constants of the trigger controller.
// Included by the package, the RTL modules and the testbench.
`ifndef TLU_SETTINGS_SVH
`define TLU_SETTINGS_SVH

// number of trigger and veto input lines
`define TLU_WIDTH 8

// register bus address width
`define TLU_ABUSWIDTH 16

// trigger word width, marker bit plus trigger number
`define TLU_DATA_WIDTH 32

// trigger word FIFO depth in words
`define TLU_FIFO_DEPTH 8

// flops per asynchronous input
`define TLU_SYNC_STAGES 3

// value read back at address 0
`define TLU_VERSION 11

`endif

// ==== design/tlu_controller.sv ====
// Top level of the trigger controller.
// Register bus, one conditioning channel per trigger input, the
// acceptance FSM and the trigger word FIFO, all on BUS_CLK.
`include "tlu_settings.svh"

module tlu_controller (
    input  logic                       BUS_CLK,
    input  logic                       RST,
    input  logic [`TLU_ABUSWIDTH-1:0]  bus_add,
    input  logic [7:0]                 bus_data_in,
    input  logic                       bus_rd,
    input  logic                       bus_wr,
    output logic [7:0]                 bus_data_out,
    input  logic [`TLU_WIDTH-1:0]      trigger,
    input  logic [`TLU_WIDTH-1:0]      trigger_veto,
    input  logic                       ext_trigger_enable,
    input  logic                       trigger_acknowledge,
    input  logic                       fifo_read,
    output logic                       trigger_enabled,
    output logic [`TLU_WIDTH-1:0]      trigger_selected,
    output logic                       trigger_accepted_flag,
    output logic                       fifo_empty,
    output logic [`TLU_DATA_WIDTH-1:0] fifo_data
);

    import tlu_pkg::*;

    logic                  soft_rst;
    logic [`TLU_WIDTH-1:0] trigger_select;
    logic [`TLU_WIDTH-1:0] trigger_invert;
    logic [`TLU_WIDTH-1:0] veto_select;
    logic [`TLU_WIDTH-1:0] trg_hit;
    logic [`TLU_WIDTH-1:0] veto_hit;
    logic                  trigger_enable_conf;
    logic [7:0]            threshold;
    logic [31:0]           counter_max;
    logic                  soft_trigger;
    logic                  counter_set;
    logic [31:0]           counter_set_value;
    logic [31:0]           trigger_count;
    logic [7:0]            lost_count;
    trigger_word_t         trigger_word;
    logic                  word_write;

    assign trigger_selected = trigger_select;

    tlu_registers i_registers (
        .BUS_CLK, .RST, .bus_add, .bus_data_in, .bus_rd, .bus_wr,
        .trigger_count, .lost_count, .bus_data_out, .soft_rst,
        .trigger_select, .trigger_invert, .veto_select,
        .trigger_enable_conf, .threshold, .counter_max,
        .soft_trigger, .counter_set, .counter_set_value
    );

    for (genvar i = 0; i < `TLU_WIDTH; i++)
    begin : g_channel
        trigger_channel i_channel (
            .BUS_CLK,
            .RST,
            .trigger        (trigger[i]),
            .trigger_veto   (trigger_veto[i]),
            .trigger_select (trigger_select[i]),
            .trigger_invert (trigger_invert[i]),
            .veto_select    (veto_select[i]),
            .trg_hit        (trg_hit[i]),
            .veto_hit       (veto_hit[i])
        );
    end

    trigger_fsm i_fsm (
        .BUS_CLK, .RST, .soft_rst, .trg_hit, .veto_hit, .soft_trigger,
        .trigger_enable_conf, .threshold, .counter_max,
        .counter_set, .counter_set_value,
        .ext_trigger_enable, .trigger_acknowledge,
        .trigger_accepted_flag, .trigger_enabled, .trigger_count,
        .trigger_word, .word_write
    );

    trigger_fifo i_fifo (
        .BUS_CLK, .RST, .soft_rst, .word_write, .trigger_word,
        .fifo_read, .fifo_data, .fifo_empty, .lost_count
    );

endmodule

// ==== design/tlu_registers.sv ====
// Byte-wide register bus of the trigger controller.
// Holds the configuration, returns readback one cycle after bus_rd and
// makes the soft reset, soft trigger and counter preset strobes.
// Reading address 8 latches the whole counter for addresses 9 to 11.
`include "tlu_settings.svh"

module tlu_registers (
    input  logic                      BUS_CLK,
    input  logic                      RST,
    input  logic [`TLU_ABUSWIDTH-1:0] bus_add,
    input  logic [7:0]                bus_data_in,
    input  logic                      bus_rd,
    input  logic                      bus_wr,
    input  logic [31:0]               trigger_count,
    input  logic [7:0]                lost_count,
    output logic [7:0]                bus_data_out,
    output logic                      soft_rst,
    output logic [`TLU_WIDTH-1:0]     trigger_select,
    output logic [`TLU_WIDTH-1:0]     trigger_invert,
    output logic [`TLU_WIDTH-1:0]     veto_select,
    output logic                      trigger_enable_conf,
    output logic [7:0]                threshold,
    output logic [31:0]               counter_max,
    output logic                      soft_trigger,
    output logic                      counter_set,
    output logic [31:0]               counter_set_value
);

    import tlu_pkg::*;

    logic       rst;
    logic       in_range;     // upper address bits all zero
    reg_addr_t  addr;
    logic       wr_en;
    logic [7:0] conf;
    logic [23:0] cnt_preset;  // bytes 8 to 10, taken on the write to 11
    logic [31:0] cnt_buf;
    logic [7:0] rd_mux;

    assign rst      = RST | soft_rst;
    assign in_range = (bus_add[`TLU_ABUSWIDTH-1:8] == '0);
    assign addr     = reg_addr_t'(bus_add[7:0]);
    assign wr_en    = bus_wr & in_range;

    // write strobes, acted on at the next edge
    assign soft_trigger      = wr_en && (addr == ADDR_SOFT_TRG);
    assign counter_set       = wr_en && (addr == ADDR_CNT3);
    assign counter_set_value = {bus_data_in, cnt_preset};

    assign trigger_enable_conf = conf[3];

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
            soft_rst <= 1'b0;
        else
            soft_rst <= wr_en && (addr == ADDR_RESET_VERSION);
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (rst)
        begin
            conf           <= '0;
            cnt_preset     <= '0;
            trigger_select <= '0;
            veto_select    <= '0;
            trigger_invert <= '0;
            counter_max    <= '0;
            threshold      <= '0;
        end
        else if (wr_en)
        begin
            case (addr)
                ADDR_CONF:        conf <= bus_data_in;
                ADDR_CNT0:        cnt_preset[7:0] <= bus_data_in;
                ADDR_CNT1:        cnt_preset[15:8] <= bus_data_in;
                ADDR_CNT2:        cnt_preset[23:16] <= bus_data_in;
                ADDR_TRG_SELECT:  trigger_select <= bus_data_in[`TLU_WIDTH-1:0];
                ADDR_VETO_SELECT: veto_select <= bus_data_in[`TLU_WIDTH-1:0];
                ADDR_TRG_INVERT:  trigger_invert <= bus_data_in[`TLU_WIDTH-1:0];
                ADDR_CNT_MAX0:    counter_max[7:0] <= bus_data_in;
                ADDR_CNT_MAX1:    counter_max[15:8] <= bus_data_in;
                ADDR_CNT_MAX2:    counter_max[23:16] <= bus_data_in;
                ADDR_CNT_MAX3:    counter_max[31:24] <= bus_data_in;
                ADDR_THRESHOLD:   threshold <= bus_data_in;
                default:          ;
            endcase
        end
    end

    // snapshot so a multi-byte read stays consistent
    always_ff @(posedge BUS_CLK)
    begin
        if (rst)
            cnt_buf <= '0;
        else if (bus_rd && in_range && addr == ADDR_CNT0)
            cnt_buf <= trigger_count;
    end

    always_comb
    begin
        rd_mux = '0;   // unmapped reads as zero
        if (in_range)
        begin
            case (addr)
                ADDR_RESET_VERSION: rd_mux = 8'(`TLU_VERSION);
                ADDR_CONF:          rd_mux = conf;
                ADDR_CNT0:          rd_mux = trigger_count[7:0];  // live value
                ADDR_CNT1:          rd_mux = cnt_buf[15:8];
                ADDR_CNT2:          rd_mux = cnt_buf[23:16];
                ADDR_CNT3:          rd_mux = cnt_buf[31:24];
                ADDR_LOST:          rd_mux = lost_count;
                ADDR_TRG_SELECT:    rd_mux = 8'(trigger_select);
                ADDR_VETO_SELECT:   rd_mux = 8'(veto_select);
                ADDR_TRG_INVERT:    rd_mux = 8'(trigger_invert);
                ADDR_CNT_MAX0:      rd_mux = counter_max[7:0];
                ADDR_CNT_MAX1:      rd_mux = counter_max[15:8];
                ADDR_CNT_MAX2:      rd_mux = counter_max[23:16];
                ADDR_CNT_MAX3:      rd_mux = counter_max[31:24];
                ADDR_THRESHOLD:     rd_mux = threshold;
                default:            rd_mux = '0;
            endcase
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (rst)
            bus_data_out <= '0;
        else if (bus_rd)
            bus_data_out <= rd_mux;
    end

endmodule

// ==== design/trigger_channel.sv ====
// Conditioning of one external trigger line and its veto line.
// Both inputs are asynchronous and pass a flop chain first; then the
// channel's invert, select and veto select bits are applied.
`include "tlu_settings.svh"

module trigger_channel (
    input  logic BUS_CLK,
    input  logic RST,
    input  logic trigger,
    input  logic trigger_veto,
    input  logic trigger_select,
    input  logic trigger_invert,
    input  logic veto_select,
    output logic trg_hit,
    output logic veto_hit
);

    logic [`TLU_SYNC_STAGES-1:0] trg_sync;
    logic [`TLU_SYNC_STAGES-1:0] veto_sync;

    always_ff @(posedge BUS_CLK)
    begin
        if (RST)
        begin
            trg_sync  <= '0;
            veto_sync <= '0;
        end
        else
        begin
            trg_sync  <= {trg_sync[`TLU_SYNC_STAGES-2:0], trigger};
            veto_sync <= {veto_sync[`TLU_SYNC_STAGES-2:0], trigger_veto};
        end
    end

    // polarity first, then the select mask
    assign trg_hit  = (trg_sync[`TLU_SYNC_STAGES-1] ^ trigger_invert) & trigger_select;
    assign veto_hit = veto_sync[`TLU_SYNC_STAGES-1] & veto_select;

endmodule

// ==== design/trigger_fifo.sv ====
// First-word-fall-through queue for trigger words.
// fifo_data is valid while fifo_empty is low and fifo_read pops it.
// A write into a full queue is dropped and counted in lost_count.
`include "tlu_settings.svh"

module trigger_fifo (
    input  logic                       BUS_CLK,
    input  logic                       RST,
    input  logic                       soft_rst,
    input  logic                       word_write,
    input  tlu_pkg::trigger_word_t     trigger_word,
    input  logic                       fifo_read,
    output logic [`TLU_DATA_WIDTH-1:0] fifo_data,
    output logic                       fifo_empty,
    output logic [7:0]                 lost_count
);

    localparam int AW = $clog2(`TLU_FIFO_DEPTH);
    localparam int CW = $clog2(`TLU_FIFO_DEPTH + 1);

    logic [`TLU_DATA_WIDTH-1:0] mem [`TLU_FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;   // words held
    logic          rst;
    logic          full;
    logic          push;
    logic          pop;

    assign rst        = RST | soft_rst;
    assign full       = (count == CW'(`TLU_FIFO_DEPTH));
    assign fifo_empty = (count == '0);
    assign push       = word_write & ~full;
    assign pop        = fifo_read & ~fifo_empty;
    assign fifo_data  = mem[rd_ptr];

    always_ff @(posedge BUS_CLK)
    begin
        if (push)
            mem[wr_ptr] <= trigger_word;
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= (wr_ptr == AW'(`TLU_FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == AW'(`TLU_FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (rst)
            lost_count <= '0;
        else if (word_write && full && lost_count != 8'hff)   // saturates
            lost_count <= lost_count + 8'd1;
    end

endmodule

// ==== design/trigger_fsm.sv ====
// Trigger acceptance FSM with threshold filter, optional external
// acknowledge, trigger counter and count limit.
// Each accepted trigger gives one cycle of trigger_accepted_flag and
// word_write, with the counter value before the increment in the word.
`include "tlu_settings.svh"

module trigger_fsm (
    input  logic                  BUS_CLK,
    input  logic                  RST,
    input  logic                  soft_rst,
    input  logic [`TLU_WIDTH-1:0] trg_hit,
    input  logic [`TLU_WIDTH-1:0] veto_hit,
    input  logic                  soft_trigger,
    input  logic                  trigger_enable_conf,
    input  logic [7:0]            threshold,
    input  logic [31:0]           counter_max,
    input  logic                  counter_set,
    input  logic [31:0]           counter_set_value,
    input  logic                  ext_trigger_enable,
    input  logic                  trigger_acknowledge,
    output logic                  trigger_accepted_flag,
    output logic                  trigger_enabled,
    output logic [31:0]           trigger_count,
    output tlu_pkg::trigger_word_t trigger_word,
    output logic                  word_write
);

    import tlu_pkg::*;

    logic       rst;
    logic       trg_any;
    logic       veto_any;
    logic       limit_reached;
    logic [7:0] qual_cnt;   // high cycles seen so far
    trg_state_t state;

    assign rst      = RST | soft_rst;
    assign trg_any  = (|trg_hit) | soft_trigger;
    assign veto_any = |veto_hit;

    assign trigger_enabled       = trigger_enable_conf & ~limit_reached;
    assign trigger_accepted_flag = (state == ACCEPT);
    assign word_write            = (state == ACCEPT);
    assign trigger_word.marker   = 1'b1;
    assign trigger_word.number   = trigger_count[30:0];

    always_ff @(posedge BUS_CLK)
    begin
        if (rst)
        begin
            state    <= IDLE;
            qual_cnt <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                    if (trigger_enabled && trg_any && !veto_any)
                    begin
                        qual_cnt <= 8'd1;
                        state    <= (threshold <= 8'd1) ? ACCEPT : QUALIFY;
                    end
                QUALIFY:
                    if (!trg_any || !trigger_enabled)
                        state <= IDLE;   // pulse too short
                    else if (9'(qual_cnt) + 9'd1 >= 9'(threshold))
                        state <= ACCEPT;
                    else
                        qual_cnt <= qual_cnt + 8'd1;
                ACCEPT:
                    state <= WAIT_ACK;
                WAIT_ACK:
                    if (!ext_trigger_enable || trigger_acknowledge)
                        state <= WAIT_LOW;
                WAIT_LOW:
                    if (!trg_any)
                        state <= IDLE;
                default:
                    state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge BUS_CLK)
    begin
        if (rst)
            trigger_count <= '0;
        else if (counter_set)
            trigger_count <= counter_set_value;
        else if (state == ACCEPT)
            trigger_count <= trigger_count + 32'd1;
    end

    // follows the count by one cycle; zero max disables the limit
    always_ff @(posedge BUS_CLK)
    begin
        if (rst)
            limit_reached <= 1'b0;
        else
            limit_reached <= (counter_max != '0) && (trigger_count >= counter_max);
    end

endmodule

// ==== sources.f ====
+incdir+common
common/tlu_pkg.sv
design/trigger_channel.sv
design/tlu_registers.sv
design/trigger_fsm.sv
design/trigger_fifo.sv
design/tlu_controller.sv
testbench/tlu_controller_assertions.sv
testbench/tlu_controller_tb.sv

// ==== testbench/tlu_controller_assertions.sv ====
// Protocol checks on the trigger controller top level.
// Bound into every tlu_controller instance; reports through $error.

module tlu_controller_assertions (
    input logic BUS_CLK,
    input logic RST,
    input logic trigger_accepted_flag,
    input logic trigger_enabled,
    input logic fifo_empty,
    input logic fifo_read
);
    timeunit 1ns;
    timeprecision 1ps;

    // accept is a single-cycle pulse
    assert property (@(posedge BUS_CLK) disable iff (RST)
        trigger_accepted_flag |=> !trigger_accepted_flag)
        else $error("trigger_accepted_flag longer than one cycle");

    assert property (@(posedge BUS_CLK) disable iff (RST)
        trigger_accepted_flag |-> trigger_enabled)
        else $error("trigger accepted while disabled");

    // queue empty right after reset
    assert property (@(posedge BUS_CLK)
        RST |=> fifo_empty)
        else $error("fifo_empty low after reset");

    assert property (@(posedge BUS_CLK) disable iff (RST)
        fifo_read |-> !fifo_empty)
        else $error("fifo_read while FIFO empty");

endmodule

bind tlu_controller tlu_controller_assertions u_assertions (.*);

// ==== testbench/tlu_controller_tb.sv ====
// Testbench for the trigger controller top level.
// Drives the register bus and the trigger inputs, models accepted
// triggers in a queue and checks every FIFO word against it.
`include "tlu_settings.svh"

module tlu_controller_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_PULSES = 28;     // pulses planned over all tests
    localparam int SPACING  = 30;     // worst-case cycles per pulse
    localparam int MARGIN   = 2000;   // bus traffic and draining
    localparam time TIMEOUT = (N_PULSES * SPACING + MARGIN) * 100;

    logic                       BUS_CLK;
    logic                       RST;
    logic [`TLU_ABUSWIDTH-1:0]  bus_add;
    logic [7:0]                 bus_data_in;
    logic                       bus_rd;
    logic                       bus_wr;
    logic [7:0]                 bus_data_out;
    logic [`TLU_WIDTH-1:0]      trigger;
    logic [`TLU_WIDTH-1:0]      trigger_veto;
    logic                       ext_trigger_enable;
    logic                       trigger_acknowledge;
    logic                       fifo_read;
    logic                       trigger_enabled;
    logic [`TLU_WIDTH-1:0]      trigger_selected;
    logic                       trigger_accepted_flag;
    logic                       fifo_empty;
    logic [`TLU_DATA_WIDTH-1:0] fifo_data;

    integer      seed = 63;
    int          errors = 0;
    int          checks = 0;
    int          flag_cnt = 0;      // accept pulses seen
    int          model_flags = 0;   // accepts the model predicts
    logic [31:0] model_cnt = 0;
    logic [31:0] model_q[$];
    logic        pop_en = 1'b1;

    tlu_controller UUT (.*);

    initial
    begin
        BUS_CLK = 1'b0;
        forever #50 BUS_CLK = ~BUS_CLK;
    end

    // trigger word layout: marker bit above the trigger number
    function automatic logic [31:0] expected_word(input logic [30:0] n);
        return {1'b1, n};
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("error %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic bus_write(input logic [15:0] a, input logic [7:0] d);
        @(posedge BUS_CLK);
        bus_add     <= a;
        bus_data_in <= d;
        bus_wr      <= 1'b1;
        @(posedge BUS_CLK);
        bus_wr <= 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] a, output logic [7:0] d);
        @(posedge BUS_CLK);
        bus_add <= a;
        bus_rd  <= 1'b1;
        @(posedge BUS_CLK);
        bus_rd <= 1'b0;
        @(negedge BUS_CLK);
        d = bus_data_out;
    endtask

    task automatic read_check(input string name, input logic [15:0] a, input logic [7:0] exp);
        logic [7:0] d;
        bus_read(a, d);
        check_val(name, d, exp);
    endtask

    // level on trigger for len cycles, then back to idle, then a gap
    task automatic pulse(input logic [7:0] level, input logic [7:0] idle, input int len);
        @(posedge BUS_CLK);
        trigger <= level;
        repeat (len) @(posedge BUS_CLK);
        trigger <= idle;
        repeat (14) @(posedge BUS_CLK);
    endtask

    task automatic model_accept(input logic stored);
        if (stored)
            model_q.push_back(expected_word(model_cnt[30:0]));
        model_cnt = model_cnt + 1;
        model_flags++;
    endtask

    task automatic drain();
        int n;
        n = 0;
        while ((model_q.size() != 0 || !fifo_empty) && n < 300)
        begin
            @(negedge BUS_CLK);
            n++;
        end
        if (n >= 300)
        begin
            errors++;
            $display("FIFO words missing or left over after draining");
        end
    endtask

    always @(negedge BUS_CLK)
    begin
        if (trigger_accepted_flag)
            flag_cnt++;
    end

    // pops the FIFO and compares each word with the model queue
    initial
    begin
        logic [31:0] exp;
        forever
        begin
            @(negedge BUS_CLK);
            if (pop_en && !fifo_empty && !RST)
            begin
                checks++;
                if (model_q.size() == 0)
                begin
                    errors++;
                    $display("unexpected FIFO word %h", fifo_data);
                end
                else
                begin
                    exp = model_q.pop_front();
                    check_val("fifo_data", fifo_data, exp);
                end
                @(posedge BUS_CLK);
                fifo_read <= 1'b1;
                @(posedge BUS_CLK);
                fifo_read <= 1'b0;
            end
        end
    end

    initial
    begin
        #(TIMEOUT);
        $display("timeout, the tests did not finish in time");
        $display("Finished with errors");
        $finish;
    end

    initial
    begin
        logic [31:0] r;
        logic [7:0]  sel;
        logic [7:0]  inv;
        int          len;
        RST = 1'b1;
        bus_add = '0;
        bus_data_in = '0;
        bus_rd = 1'b0;
        bus_wr = 1'b0;
        trigger = '0;
        trigger_veto = '0;
        ext_trigger_enable = 1'b0;
        trigger_acknowledge = 1'b0;
        fifo_read = 1'b0;
        repeat (4) @(posedge BUS_CLK);
        RST <= 1'b0;
        @(negedge BUS_CLK);
        check_val("trigger_enabled", trigger_enabled, 0);
        check_val("fifo_empty", fifo_empty, 1);

        // register access
        read_check("version", 16'd0, 8'(`TLU_VERSION));
        bus_write(16'd13, 8'ha5);
        bus_write(16'd17, 8'h3c);
        bus_write(16'd21, 8'h5a);
        bus_write(16'd33, 8'h07);
        bus_write(16'd25, 8'h11);
        bus_write(16'd28, 8'h44);
        read_check("trg_select", 16'd13, 8'ha5);
        read_check("veto_select", 16'd17, 8'h3c);
        read_check("trg_invert", 16'd21, 8'h5a);
        read_check("threshold", 16'd33, 8'h07);
        read_check("cnt_max0", 16'd25, 8'h11);
        read_check("cnt_max3", 16'd28, 8'h44);
        read_check("unmapped", 16'd5, 8'h00);
        read_check("out_of_range", 16'h010d, 8'h00);
        bus_write(16'd0, 8'h00);

        // trigger selection with random masks, idle level follows invert
        r = $random(seed);
        sel = r[7:0];
        r = $random(seed);
        inv = r[7:0];
        bus_write(16'd13, sel);
        bus_write(16'd21, inv);
        @(posedge BUS_CLK);
        trigger <= inv;
        repeat (6) @(posedge BUS_CLK);
        bus_write(16'd1, 8'h08);
        @(negedge BUS_CLK);
        check_val("trigger_selected", trigger_selected, sel);
        for (int ch = 0; ch < `TLU_WIDTH; ch++)
        begin
            r = $random(seed);
            len = 2 + int'(r[2:0]);
            if (sel[ch])
                model_accept(1'b1);
            pulse(inv ^ (8'd1 << ch), inv, len);
        end
        drain();
        bus_write(16'd1, 8'h00);
        @(posedge BUS_CLK);
        trigger <= '0;
        bus_write(16'd21, 8'h00);
        bus_write(16'd13, 8'hff);
        repeat (6) @(posedge BUS_CLK);
        bus_write(16'd1, 8'h08);

        // veto on channel 0 blocks the pulse
        @(posedge BUS_CLK);
        trigger_veto <= 8'h01;
        bus_write(16'd17, 8'h01);
        pulse(8'h02, 8'h00, 4);
        @(posedge BUS_CLK);
        trigger_veto <= 8'h00;
        repeat (5) @(posedge BUS_CLK);

        // threshold 5: short pulse dropped, long one accepted
        bus_write(16'd33, 8'd5);
        pulse(8'h04, 8'h00, 3);
        model_accept(1'b1);
        pulse(8'h04, 8'h00, 8);
        bus_write(16'd33, 8'd0);
        model_accept(1'b1);
        bus_write(16'd34, 8'h01);
        repeat (10) @(posedge BUS_CLK);
        drain();

        // external acknowledge holds off the second trigger
        @(posedge BUS_CLK);
        ext_trigger_enable <= 1'b1;
        model_accept(1'b1);
        pulse(8'h01, 8'h00, 3);
        pulse(8'h01, 8'h00, 3);
        @(posedge BUS_CLK);
        trigger_acknowledge <= 1'b1;
        @(posedge BUS_CLK);
        trigger_acknowledge <= 1'b0;
        ext_trigger_enable <= 1'b0;
        repeat (4) @(posedge BUS_CLK);
        model_accept(1'b1);
        pulse(8'h01, 8'h00, 3);
        drain();

        // overflow, FIFO not popped
        pop_en = 1'b0;
        for (int i = 0; i < `TLU_FIFO_DEPTH + 2; i++)
        begin
            pulse(8'h08, 8'h00, 3);
            model_accept(i < `TLU_FIFO_DEPTH);
        end
        read_check("lost_count", 16'd12, 8'd2);
        pop_en = 1'b1;
        drain();

        // counter preset, latched readback and limit
        bus_write(16'd8, 8'h78);
        bus_write(16'd9, 8'h56);
        bus_write(16'd10, 8'h34);
        bus_write(16'd11, 8'h12);
        model_cnt = 32'h12345678;
        model_accept(1'b1);
        pulse(8'h01, 8'h00, 3);
        drain();
        read_check("cnt0", 16'd8, model_cnt[7:0]);
        read_check("cnt1", 16'd9, model_cnt[15:8]);
        read_check("cnt2", 16'd10, model_cnt[23:16]);
        read_check("cnt3", 16'd11, model_cnt[31:24]);
        r = model_cnt + 32'd2;
        bus_write(16'd25, r[7:0]);
        bus_write(16'd26, r[15:8]);
        bus_write(16'd27, r[23:16]);
        bus_write(16'd28, r[31:24]);
        for (int i = 0; i < 3; i++)
        begin
            if (i < 2)
                model_accept(1'b1);
            pulse(8'h01, 8'h00, 3);
        end
        drain();
        @(negedge BUS_CLK);
        check_val("trigger_enabled", trigger_enabled, 0);

        // soft reset clears counter, configuration, FIFO and lost count
        pop_en = 1'b0;
        bus_write(16'd25, 8'h00);
        bus_write(16'd26, 8'h00);
        bus_write(16'd27, 8'h00);
        bus_write(16'd28, 8'h00);
        model_accept(1'b1);
        bus_write(16'd34, 8'h01);
        repeat (4) @(posedge BUS_CLK);
        @(negedge BUS_CLK);
        check_val("fifo_empty", fifo_empty, 0);
        bus_write(16'd0, 8'h00);
        repeat (2) @(posedge BUS_CLK);
        @(negedge BUS_CLK);
        check_val("fifo_empty", fifo_empty, 1);
        model_q.delete();
        model_cnt = 0;
        pop_en = 1'b1;
        read_check("conf", 16'd1, 8'h00);
        read_check("trg_select", 16'd13, 8'h00);
        read_check("lost_count", 16'd12, 8'h00);
        read_check("cnt0", 16'd8, 8'h00);
        read_check("cnt3", 16'd11, 8'h00);

        repeat (10) @(posedge BUS_CLK);
        check_val("trigger_accepted_flag pulses", flag_cnt, model_flags);
        $display("%0d errors in %0d checks", errors, checks);
        if (errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule
